// File: Makefile
# Verilator build and run of the memory stage testbench

SIM  := obj_dir/Vtb_mem_stage
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): filelist.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f filelist.f \
		--top-module tb_mem_stage -o Vtb_mem_stage

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "^NO ERRORS$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_mem_stage.sv
module tb_mem_stage;

    localparam int N_GROUP = 8;
    localparam int N_ALU   = 8;
    localparam int N_FETCH = 16;
    localparam int N_CONC  = 6;
    // each group is three stores, each followed by five loads
    localparam int NUM_OPS = 1 + N_GROUP * 3 * 6 + N_ALU * 2 + N_FETCH + N_CONC * 2;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 8;

    logic        clk;
    logic        rst;
    logic        ifu_valid_i;
    logic        wd_i;
    logic [4:0]  wreg_i;
    logic [31:0] alu_result_i;
    logic [31:0] mem_wdata_i;
    logic [2:0]  load_type_i;
    logic [1:0]  store_type_i;
    logic [31:0] csr_wdata_i;
    logic        fetch_strobe_i;
    logic [31:0] fetch_pc_i;
    logic        lsu_valid_o;
    logic        memory_inst_o;
    logic        wd_o;
    logic [4:0]  wreg_o;
    logic [31:0] wdata_o;
    logic [31:0] csr_wdata_o;
    logic [31:0] inst_o;
    logic        inst_valid_o;

    logic [31:0] ref_mem [mem_pkg::MEM_WORDS];
    integer      seed;
    logic [31:0] stored_addrs [$];

    // what the compare process expects at the next pulses
    logic        lsu_pending;
    logic        fetch_pending;
    logic        exp_mem;
    logic        exp_wdata_known;
    logic [31:0] exp_wdata;
    logic        exp_wd;
    logic [4:0]  exp_wreg;
    logic [31:0] exp_csr;
    logic [31:0] exp_inst;
    int          lsu_seen;
    int          fetch_seen;

    mem_stage_top i_mem_stage_top (
        .clk            (clk),
        .rst            (rst),
        .ifu_valid_i    (ifu_valid_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .alu_result_i   (alu_result_i),
        .mem_wdata_i    (mem_wdata_i),
        .load_type_i    (load_type_i),
        .store_type_i   (store_type_i),
        .csr_wdata_i    (csr_wdata_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_pc_i     (fetch_pc_i),
        .lsu_valid_o    (lsu_valid_o),
        .memory_inst_o  (memory_inst_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o),
        .csr_wdata_o    (csr_wdata_o),
        .inst_o         (inst_o),
        .inst_valid_o   (inst_valid_o)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // new word after a store of the given width at byte offset off
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                                input logic [1:0] st, input logic [1:0] off);
        logic [31:0] res;
        res = old;
        case (st)
            mem_pkg::STORE_SB: res[8*off +: 8] = data[7:0];
            mem_pkg::STORE_SH: res[8*off +: 16] = data[15:0];
            mem_pkg::STORE_SW: res = data;
            default: res = old;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] extract_load(input logic [31:0] word, input logic [2:0] ld,
                                                 input logic [1:0] off);
        logic [7:0]         b;
        logic [15:0]        h;
        logic signed [31:0] r;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (ld)
            mem_pkg::LOAD_LB:  r = 32'($signed(b));
            mem_pkg::LOAD_LH:  r = 32'($signed(h));
            mem_pkg::LOAD_LBU: r = {24'd0, b};
            mem_pkg::LOAD_LHU: r = {16'd0, h};
            default:           r = word;
        endcase
        return r;
    endfunction

    // aligned byte offset for a store width
    function automatic logic [1:0] rand_offset(input logic [1:0] st);
        logic [1:0] off;
        off = 2'($random(seed));
        if (st == mem_pkg::STORE_SW) begin
            off = 2'd0;
        end else if (st == mem_pkg::STORE_SH) begin
            off = off & 2'b10;
        end
        return off;
    endfunction

    // sets the lsu inputs and the expected writeback, updates the model on stores
    task automatic prepare_lsu(input logic [2:0] ld, input logic [1:0] st,
                               input logic [31:0] addr, input logic [31:0] data);
        logic [mem_pkg::MEM_AW-1:0] w;
        w = addr[mem_pkg::MEM_AW+1:2];
        wd_i         = 1'($random(seed));
        wreg_i       = 5'($random(seed));
        csr_wdata_i  = $random(seed);
        alu_result_i = addr;
        mem_wdata_i  = data;
        load_type_i  = ld;
        store_type_i = st;
        exp_wd       = wd_i;
        exp_wreg     = wreg_i;
        exp_csr      = csr_wdata_i;
        exp_mem      = (ld != mem_pkg::LOAD_NONE) || (st != mem_pkg::STORE_NONE);
        exp_wdata_known = 1'b1;
        if (st != mem_pkg::STORE_NONE) begin
            ref_mem[w] = merge_store(ref_mem[w], data, st, addr[1:0]);
            exp_wdata_known = 1'b0;
        end else if (ld != mem_pkg::LOAD_NONE) begin
            exp_wdata = extract_load(ref_mem[w], ld, addr[1:0]);
        end else begin
            exp_wdata = addr;
        end
    endtask

    task automatic lsu_op(input logic [2:0] ld, input logic [1:0] st,
                          input logic [31:0] addr, input logic [31:0] data);
        int start;
        start = lsu_seen;
        @(posedge clk);
        #1;
        prepare_lsu(ld, st, addr, data);
        ifu_valid_i = 1'b1;
        @(posedge clk);
        #1;
        ifu_valid_i = 1'b0;
        lsu_pending = 1'b1;
        wait (lsu_seen != start);
    endtask

    task automatic fetch_op(input logic [31:0] pc);
        int start;
        start = fetch_seen;
        @(posedge clk);
        #1;
        fetch_pc_i     = pc;
        exp_inst       = ref_mem[pc[mem_pkg::MEM_AW+1:2]];
        fetch_strobe_i = 1'b1;
        @(posedge clk);
        #1;
        fetch_strobe_i = 1'b0;
        fetch_pending  = 1'b1;
        wait (fetch_seen != start);
    endtask

    // store and fetch of the same word sampled on one edge
    task automatic store_and_fetch(input logic [1:0] st, input logic [31:0] addr,
                                   input logic [31:0] data);
        int lsu_start;
        int fetch_start;
        lsu_start   = lsu_seen;
        fetch_start = fetch_seen;
        @(posedge clk);
        #1;
        prepare_lsu(mem_pkg::LOAD_NONE, st, addr, data);
        fetch_pc_i     = {addr[31:2], 2'b00};
        exp_inst       = ref_mem[addr[mem_pkg::MEM_AW+1:2]];
        ifu_valid_i    = 1'b1;
        fetch_strobe_i = 1'b1;
        @(posedge clk);
        #1;
        ifu_valid_i    = 1'b0;
        fetch_strobe_i = 1'b0;
        lsu_pending    = 1'b1;
        fetch_pending  = 1'b1;
        wait ((lsu_seen != lsu_start) && (fetch_seen != fetch_start));
    endtask

    task automatic load_all_types(input logic [31:0] base);
        logic [1:0] half_off;
        logic [1:0] byte_off;
        half_off = 2'($random(seed)) & 2'b10;
        byte_off = 2'($random(seed));
        lsu_op(mem_pkg::LOAD_LW, mem_pkg::STORE_NONE, base, 32'd0);
        lsu_op(mem_pkg::LOAD_LH, mem_pkg::STORE_NONE, base | 32'(half_off), 32'd0);
        lsu_op(mem_pkg::LOAD_LHU, mem_pkg::STORE_NONE, base | 32'(half_off), 32'd0);
        lsu_op(mem_pkg::LOAD_LB, mem_pkg::STORE_NONE, base | 32'(byte_off), 32'd0);
        lsu_op(mem_pkg::LOAD_LBU, mem_pkg::STORE_NONE, base | 32'(byte_off), 32'd0);
    endtask

    task automatic run_store_load_tests();
        logic [31:0] base;
        logic [1:0]  st;
        for (int g = 0; g < N_GROUP; g++) begin
            base = {20'd0, 10'($random(seed)), 2'b00};
            stored_addrs.push_back(base);
            // whole word first so narrow stores land on known neighbors
            for (int k = 0; k < 3; k++) begin
                st = 2'(3 - k);
                lsu_op(mem_pkg::LOAD_NONE, st, base | 32'(rand_offset(st)), $random(seed));
                load_all_types(base);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (lsu_valid_o) begin
                check_value("lsu_valid_o without an instruction", 32'(lsu_pending), 32'd1);
                if (exp_wdata_known) begin
                    check_value("wdata_o", wdata_o, exp_wdata);
                end
                check_value("wd_o", 32'(wd_o), 32'(exp_wd));
                check_value("wreg_o", 32'(wreg_o), 32'(exp_wreg));
                check_value("csr_wdata_o", csr_wdata_o, exp_csr);
                lsu_pending = 1'b0;
                lsu_seen++;
            end else if (lsu_pending) begin
                check_value("memory_inst_o while busy", 32'(memory_inst_o), 32'(exp_mem));
            end else begin
                check_value("memory_inst_o while idle", 32'(memory_inst_o), 32'd0);
            end
            if (inst_valid_o) begin
                check_value("inst_valid_o without a fetch", 32'(fetch_pending), 32'd1);
                check_value("inst_o", inst_o, exp_inst);
                fetch_pending = 1'b0;
                fetch_seen++;
            end
        end
    end

    // watchdog sized from the operation count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run hung, no finish after %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] addr;
        logic [1:0]  st;
        seed           = 66666;
        clk            = 1'b0;
        rst            = 1'b1;
        ifu_valid_i    = 1'b0;
        wd_i           = 1'b0;
        wreg_i         = 5'd0;
        alu_result_i   = 32'd0;
        mem_wdata_i    = 32'd0;
        load_type_i    = mem_pkg::LOAD_NONE;
        store_type_i   = mem_pkg::STORE_NONE;
        csr_wdata_i    = 32'd0;
        fetch_strobe_i = 1'b0;
        fetch_pc_i     = 32'd0;
        lsu_pending    = 1'b0;
        fetch_pending  = 1'b0;
        lsu_seen       = 0;
        fetch_seen     = 0;
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = 32'd0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // outputs quiet after reset, untouched memory reads zero
        @(negedge clk);
        check_value("lsu_valid_o after reset", 32'(lsu_valid_o), 32'd0);
        check_value("inst_valid_o after reset", 32'(inst_valid_o), 32'd0);
        check_value("memory_inst_o after reset", 32'(memory_inst_o), 32'd0);
        lsu_op(mem_pkg::LOAD_LW, mem_pkg::STORE_NONE, 32'h0000_0ffc, 32'd0);

        run_store_load_tests();

        // alu results pass through and leave memory alone
        for (int i = 0; i < N_ALU; i++) begin
            addr = stored_addrs[i % stored_addrs.size()];
            lsu_op(mem_pkg::LOAD_NONE, mem_pkg::STORE_NONE, addr, $random(seed));
            lsu_op(mem_pkg::LOAD_LW, mem_pkg::STORE_NONE, addr, 32'd0);
        end

        for (int i = 0; i < N_FETCH; i++) begin
            fetch_op(stored_addrs[i % stored_addrs.size()]);
        end

        // lsu wins the port, so the fetch sees the new word
        for (int i = 0; i < N_CONC; i++) begin
            st   = 2'(1 + ($unsigned($random(seed)) % 3));
            addr = {20'd0, 10'($random(seed)), 2'b00} | 32'(rand_offset(st));
            store_and_fetch(st, addr, $random(seed));
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: filelist.f
verilog/mem_pkg.sv
verilog/unified_sram.sv
verilog/mem_arbiter.sv
verilog/fetch_port.sv
verilog/load_store_unit.sv
verilog/mem_stage_top.sv
bench/tb_mem_stage.sv

// File: verilog/fetch_port.sv
module fetch_port (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_strobe_i,
    input  logic [31:0]                fetch_pc_i,
    input  logic                       fetch_gnt_i,
    input  logic                       fetch_rvalid_i,
    input  logic [31:0]                sram_rdata_i,
    output logic                       fetch_req_o,
    output logic [mem_pkg::MEM_AW-1:0] fetch_addr_o,
    output logic [31:0]                inst_o,
    output logic                       inst_valid_o
);

    logic                       req_q;
    logic                       wait_q;
    logic [mem_pkg::MEM_AW-1:0] pc_word_q;

    // busy from strobe until the word comes back
    logic busy;
    assign busy = req_q || wait_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q        <= 1'b0;
            wait_q       <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            if (!busy && fetch_strobe_i) begin
                req_q <= 1'b1;
            end
            // request drops once the arbiter lets us in
            if (req_q && fetch_gnt_i) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (wait_q && fetch_rvalid_i) begin
                wait_q       <= 1'b0;
                inst_valid_o <= 1'b1;
            end
        end
    end

    // pc and instruction word
    always_ff @(posedge clk) begin
        if (!busy && fetch_strobe_i) begin
            pc_word_q <= fetch_pc_i[mem_pkg::MEM_AW+1:2];
        end
        if (wait_q && fetch_rvalid_i) begin
            inst_o <= sram_rdata_i;
        end
    end

    assign fetch_req_o  = req_q;
    assign fetch_addr_o = pc_word_q;

endmodule

// File: verilog/load_store_unit.sv
module load_store_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ifu_valid_i,
    input  logic                       wd_i,
    input  logic [4:0]                 wreg_i,
    input  logic [31:0]                alu_result_i,
    input  logic [31:0]                mem_wdata_i,
    input  logic [2:0]                 load_type_i,
    input  logic [1:0]                 store_type_i,
    input  logic [31:0]                csr_wdata_i,
    input  logic                       lsu_gnt_i,
    input  logic                       lsu_rvalid_i,
    input  logic [31:0]                sram_rdata_i,
    output logic                       lsu_req_o,
    output logic                       lsu_we_o,
    output logic [mem_pkg::MEM_AW-1:0] lsu_addr_o,
    output logic [3:0]                 lsu_wmask_o,
    output mem_pkg::mem_word_u         lsu_wdata_o,
    output logic                       memory_inst_o,
    output logic                       lsu_valid_o,
    output logic                       wd_o,
    output logic [4:0]                 wreg_o,
    output logic [31:0]                wdata_o,
    output logic [31:0]                csr_wdata_o
);

    logic [1:0]  state_q;
    logic [1:0]  state_d;

    // latched instruction fields
    logic        wd_q;
    logic [4:0]  wreg_q;
    logic [31:0] alu_q;
    logic [31:0] store_data_q;
    logic [2:0]  load_q;
    logic [1:0]  store_q;
    logic [31:0] csr_q;
    logic [31:0] load_data_q;

    logic        is_mem_in;
    logic        is_load;
    logic        is_mem;
    logic        take;
    logic        finish;
    logic [3:0]  base_mask;
    logic [31:0] load_ext;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    mem_pkg::mem_word_u rd_word;

    assign is_mem_in = (load_type_i != mem_pkg::LOAD_NONE) ||
                       (store_type_i != mem_pkg::STORE_NONE);
    assign is_load   = load_q != mem_pkg::LOAD_NONE;
    assign is_mem    = is_load || (store_q != mem_pkg::STORE_NONE);

    // accept a new instruction only when idle
    assign take   = (state_q == mem_pkg::LSU_IDLE) && ifu_valid_i;
    // loads wait for their data, stores and alu ops finish at once
    assign finish = (state_q == mem_pkg::LSU_WAIT) && (!is_load || lsu_rvalid_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::LSU_IDLE: begin
                if (ifu_valid_i) begin
                    state_d = is_mem_in ? mem_pkg::LSU_ACCESS : mem_pkg::LSU_WAIT;
                end
            end
            mem_pkg::LSU_ACCESS: begin
                if (lsu_gnt_i) begin
                    state_d = mem_pkg::LSU_WAIT;
                end
            end
            mem_pkg::LSU_WAIT: begin
                if (finish) begin
                    state_d = mem_pkg::LSU_IDLE;
                end
            end
            default: begin
                state_d = mem_pkg::LSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= mem_pkg::LSU_IDLE;
            lsu_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            lsu_valid_o <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wd_q         <= wd_i;
            wreg_q       <= wreg_i;
            alu_q        <= alu_result_i;
            store_data_q <= mem_wdata_i;
            load_q       <= load_type_i;
            store_q      <= store_type_i;
            csr_q        <= csr_wdata_i;
        end
        if (finish && is_load) begin
            load_data_q <= load_ext;
        end
    end

    // request side
    assign lsu_req_o  = state_q == mem_pkg::LSU_ACCESS;
    assign lsu_we_o   = store_q != mem_pkg::STORE_NONE;
    assign lsu_addr_o = alu_q[mem_pkg::MEM_AW+1:2];

    always_comb begin
        case (store_q)
            mem_pkg::STORE_SB: base_mask = mem_pkg::MASK_BYTE;
            mem_pkg::STORE_SH: base_mask = mem_pkg::MASK_HALF;
            mem_pkg::STORE_SW: base_mask = mem_pkg::MASK_WORD;
            default:           base_mask = 4'b0000;
        endcase
    end

    // move mask and data up to the addressed lanes
    assign lsu_wmask_o = base_mask << alu_q[1:0];
    assign lsu_wdata_o = store_data_q << {alu_q[1:0], 3'b000};

    // load lane select
    assign rd_word = sram_rdata_i;
    assign rd_byte = rd_word.bytes[alu_q[1:0]];
    assign rd_half = {rd_word.bytes[{alu_q[1], 1'b1}], rd_word.bytes[{alu_q[1], 1'b0}]};

    always_comb begin
        case (load_q)
            mem_pkg::LOAD_LB:  load_ext = {{24{rd_byte[7]}}, rd_byte};
            mem_pkg::LOAD_LH:  load_ext = {{16{rd_half[15]}}, rd_half};
            mem_pkg::LOAD_LBU: load_ext = {24'd0, rd_byte};
            mem_pkg::LOAD_LHU: load_ext = {16'd0, rd_half};
            default:           load_ext = rd_word.word;
        endcase
    end

    // writeback side
    assign memory_inst_o = (state_q != mem_pkg::LSU_IDLE) && is_mem;
    assign wd_o          = wd_q;
    assign wreg_o        = wreg_q;
    assign csr_wdata_o   = csr_q;
    assign wdata_o       = is_load ? load_data_q : alu_q;

endmodule

// File: verilog/mem_arbiter.sv
module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lsu_req_i,
    input  logic                       lsu_we_i,
    input  logic [mem_pkg::MEM_AW-1:0] lsu_addr_i,
    input  logic [3:0]                 lsu_wmask_i,
    input  mem_pkg::mem_word_u         lsu_wdata_i,
    input  logic                       fetch_req_i,
    input  logic [mem_pkg::MEM_AW-1:0] fetch_addr_i,
    output logic                       lsu_gnt_o,
    output logic                       fetch_gnt_o,
    output logic                       sram_en_o,
    output logic                       sram_we_o,
    output logic [mem_pkg::MEM_AW-1:0] sram_addr_o,
    output logic [3:0]                 sram_wmask_o,
    output mem_pkg::mem_word_u         sram_wdata_o,
    output logic                       lsu_rvalid_o,
    output logic                       fetch_rvalid_o
);

    // fixed priority, lsu first
    assign lsu_gnt_o   = lsu_req_i;
    assign fetch_gnt_o = fetch_req_i && !lsu_req_i;

    // port steering from the winner
    assign sram_en_o    = lsu_gnt_o || fetch_gnt_o;
    assign sram_we_o    = lsu_gnt_o && lsu_we_i;
    assign sram_addr_o  = lsu_gnt_o ? lsu_addr_i : fetch_addr_i;
    // fetch never writes
    assign sram_wmask_o = lsu_gnt_o ? lsu_wmask_i : 4'b0000;
    assign sram_wdata_o = lsu_wdata_i;

    // remember who owns next cycle's read data
    always_ff @(posedge clk) begin
        if (rst) begin
            lsu_rvalid_o   <= 1'b0;
            fetch_rvalid_o <= 1'b0;
        end else begin
            lsu_rvalid_o   <= lsu_gnt_o && !lsu_we_i;
            fetch_rvalid_o <= fetch_gnt_o;
        end
    end

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

    // unified memory geometry, word addressed
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = 10;

    // load type codes, zero means the instruction does not load
    localparam logic [2:0] LOAD_NONE = 3'd0;
    localparam logic [2:0] LOAD_LB   = 3'd1;
    localparam logic [2:0] LOAD_LH   = 3'd2;
    localparam logic [2:0] LOAD_LW   = 3'd3;
    localparam logic [2:0] LOAD_LBU  = 3'd4;
    localparam logic [2:0] LOAD_LHU  = 3'd5;

    // store type codes, zero means no store
    localparam logic [1:0] STORE_NONE = 2'd0;
    localparam logic [1:0] STORE_SB   = 2'd1;
    localparam logic [1:0] STORE_SH   = 2'd2;
    localparam logic [1:0] STORE_SW   = 2'd3;

    // byte enables for each store width, before lane shifting
    localparam logic [3:0] MASK_BYTE = 4'b0001;
    localparam logic [3:0] MASK_HALF = 4'b0011;
    localparam logic [3:0] MASK_WORD = 4'b1111;

    // lsu FSM states
    // idle waits for ifu_valid, access holds the request,
    // wait finishes the instruction and raises the pulse
    localparam logic [1:0] LSU_IDLE   = 2'd0;
    localparam logic [1:0] LSU_ACCESS = 2'd1;
    localparam logic [1:0] LSU_WAIT   = 2'd2;

    // one memory word, seen whole or as four byte lanes
    // lane 0 is the least significant byte (little endian)
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } mem_word_u;

endpackage

// File: verilog/mem_stage_top.sv
module mem_stage_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        ifu_valid_i,
    input  logic        wd_i,
    input  logic [4:0]  wreg_i,
    input  logic [31:0] alu_result_i,
    input  logic [31:0] mem_wdata_i,
    input  logic [2:0]  load_type_i,
    input  logic [1:0]  store_type_i,
    input  logic [31:0] csr_wdata_i,
    input  logic        fetch_strobe_i,
    input  logic [31:0] fetch_pc_i,
    output logic        lsu_valid_o,
    output logic        memory_inst_o,
    output logic        wd_o,
    output logic [4:0]  wreg_o,
    output logic [31:0] wdata_o,
    output logic [31:0] csr_wdata_o,
    output logic [31:0] inst_o,
    output logic        inst_valid_o
);

    // lsu to arbiter
    logic                       lsu_req;
    logic                       lsu_we;
    logic [mem_pkg::MEM_AW-1:0] lsu_addr;
    logic [3:0]                 lsu_wmask;
    mem_pkg::mem_word_u         lsu_wdata;
    logic                       lsu_gnt;
    logic                       lsu_rvalid;

    // fetch to arbiter
    logic                       fetch_req;
    logic [mem_pkg::MEM_AW-1:0] fetch_addr;
    logic                       fetch_gnt;
    logic                       fetch_rvalid;

    // shared sram port
    logic                       sram_en;
    logic                       sram_we;
    logic [mem_pkg::MEM_AW-1:0] sram_addr;
    logic [3:0]                 sram_wmask;
    mem_pkg::mem_word_u         sram_wdata;
    logic [31:0]                sram_rdata;

    load_store_unit i_load_store_unit (
        .clk           (clk),
        .rst           (rst),
        .ifu_valid_i   (ifu_valid_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .alu_result_i  (alu_result_i),
        .mem_wdata_i   (mem_wdata_i),
        .load_type_i   (load_type_i),
        .store_type_i  (store_type_i),
        .csr_wdata_i   (csr_wdata_i),
        .lsu_gnt_i     (lsu_gnt),
        .lsu_rvalid_i  (lsu_rvalid),
        .sram_rdata_i  (sram_rdata),
        .lsu_req_o     (lsu_req),
        .lsu_we_o      (lsu_we),
        .lsu_addr_o    (lsu_addr),
        .lsu_wmask_o   (lsu_wmask),
        .lsu_wdata_o   (lsu_wdata),
        .memory_inst_o (memory_inst_o),
        .lsu_valid_o   (lsu_valid_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .csr_wdata_o   (csr_wdata_o)
    );

    fetch_port i_fetch_port (
        .clk            (clk),
        .rst            (rst),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_gnt_i    (fetch_gnt),
        .fetch_rvalid_i (fetch_rvalid),
        .sram_rdata_i   (sram_rdata),
        .fetch_req_o    (fetch_req),
        .fetch_addr_o   (fetch_addr),
        .inst_o         (inst_o),
        .inst_valid_o   (inst_valid_o)
    );

    mem_arbiter i_mem_arbiter (
        .clk            (clk),
        .rst            (rst),
        .lsu_req_i      (lsu_req),
        .lsu_we_i       (lsu_we),
        .lsu_addr_i     (lsu_addr),
        .lsu_wmask_i    (lsu_wmask),
        .lsu_wdata_i    (lsu_wdata),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .lsu_gnt_o      (lsu_gnt),
        .fetch_gnt_o    (fetch_gnt),
        .sram_en_o      (sram_en),
        .sram_we_o      (sram_we),
        .sram_addr_o    (sram_addr),
        .sram_wmask_o   (sram_wmask),
        .sram_wdata_o   (sram_wdata),
        .lsu_rvalid_o   (lsu_rvalid),
        .fetch_rvalid_o (fetch_rvalid)
    );

    unified_sram i_unified_sram (
        .clk     (clk),
        .en_i    (sram_en),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .wmask_i (sram_wmask),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

endmodule

// File: verilog/unified_sram.sv
module unified_sram (
    input  logic                      clk,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [mem_pkg::MEM_AW-1:0] addr_i,
    input  logic [3:0]                wmask_i,
    input  mem_pkg::mem_word_u        wdata_i,
    output logic [31:0]               rdata_o
);

    mem_pkg::mem_word_u mem [mem_pkg::MEM_WORDS];

    // contents start cleared
    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // lane writes, untouched lanes keep their old bytes
    always @(posedge clk) begin
        if (en_i && we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wmask_i[lane]) begin
                    mem[addr_i].bytes[lane] <= wdata_i.bytes[lane];
                end
            end
        end
    end

    // registered read, data valid the cycle after the access
    always_ff @(posedge clk) begin
        if (en_i && !we_i) begin
            rdata_o <= mem[addr_i].word;
        end
    end

endmodule
